// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_front_end
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean

// File: src.f
+incdir+test
verilog/x86_decode_pkg.sv
verilog/insn_fetch.sv
verilog/insn_queue.sv
verilog/insn_decode.sv
verilog/uop_issue.sv
verilog/x86_front_end.sv
test/front_end_assertions.sv
test/tb_front_end.sv

// File: test/front_end_assertions.sv
`timescale 1ns/1ps

module front_end_assertions (
        input logic                 reset,
        input logic                 clk2,
        input logic                 code_ready,
        input x86_decode_pkg::uop_t uop,
        input logic                 uop_valid,
        input logic                 uop_ready,
        input logic [31:0]          eip
);

        logic step_done;

        assign step_done = uop_valid && uop_ready && uop.last;  // final step taken

        hold_step: assert property (@(posedge reset) disable iff (clk2)
                uop_valid && !uop_ready |=> uop_valid && $stable(uop))
                else $error("uop dropped or changed while stalled");

        quiet_reset: assert property (@(posedge reset) clk2 |=> !uop_valid && !code_ready)
                else $error("code_ready or uop_valid high right after a reset cycle");

        eip_hold: assert property (@(posedge reset) disable iff (clk2)
                !step_done |=> $stable(eip))
                else $error("eip moved without a final step");

        eip_move: assert property (@(posedge reset) disable iff (clk2)
                step_done |=> eip != $past(eip))
                else $error("eip did not advance on a final step");

endmodule

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] widen_signed(input logic [7:0] b);
        return {{24{b[7]}}, b};
endfunction

// x86 stores imm32 and disp32 low byte first
function automatic logic [31:0] le_bytes(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
endfunction

// bytes in stream order from the top, steps as {load, select} from the top
task automatic emit(input logic [47:0] bytes, input int len, input logic [23:0] steps,
                    input int ns, input logic [31:0] imm);
        x86_decode_pkg::uop_t s;
        logic [7:0]           st;
        for (int i = 0; i < len; i++) begin
                byte_q.push_back(bytes[47 - 8*i -: 8]);
                end_q.push_back(i == len - 1);
        end
        for (int i = 0; i < ns; i++) begin
                st = steps[23 - 8*i -: 8];
                s.load = x86_decode_pkg::reg_code_t'(st[7:4]);
                s.select = st[3:0];
                s.imm = imm;
                s.eip = gen_eip;                // first byte of the instruction
                s.last = (i == ns - 1);
                pend_q.push_back(s);
                pend_next_q.push_back(gen_eip + 32'(len));
        end
        pend_cnt_q.push_back(ns);
        gen_eip = gen_eip + 32'(len);
endtask

task automatic gen_insn();
        logic [31:0] v;
        logic [31:0] w;
        logic [7:0]  modrm;
        v = next_rand();
        w = next_rand();
        case (rand_below(14))
        0: emit({8'h55, 40'h0}, 1, {8'h12, 8'h11, 8'h00}, 2, '0);       // push ebp
        1: emit({8'h53, 40'h0}, 1, {8'h12, 8'h17, 8'h00}, 2, '0);       // push ebx
        2: emit({8'h5d, 40'h0}, 1, {8'h24, 8'h22, 8'h00}, 2, '0);       // pop ebp
        3: emit({8'hc3, 40'h0}, 1, {8'h44, 8'h22, 8'h00}, 2, '0);       // ret
        4: emit({8'hc9, 40'h0}, 1, {8'h15, 8'h55, 8'h21}, 3, '0);       // leave
        5: begin
                modrm = 8'hc3 + 8'(rand_below(61));
                emit({8'h89, modrm, 32'h0}, 2, {(modrm >= 8'he5) ? 8'h22 : 8'h26, 16'h0},
                     1, '0);
        end
        6: emit({8'h6a, v[7:0], 32'h0}, 2, {8'h12, 8'h14, 8'h00}, 2, widen_signed(v[7:0]));
        7: begin
                modrm = (w[9:8] == 2'd0) ? 8'he8 : (w[9] ? 8'hc4 : 8'hec);
                emit({8'h83, modrm, v[7:0], 24'h0}, 3, {(modrm == 8'he8) ? 8'h36 : 8'h12,
                     16'h0}, 1, widen_signed(v[7:0]));
        end
        8: emit({8'h8b, 5'b01000, w[2:0], v[7:0], 24'h0}, 3, {8'h55, 8'h36, 8'h00}, 2,
                widen_signed(v[7:0]));                          // disp8
        9: emit({8'h8b, 5'b10000, w[2:0], le_bytes(v)}, 6, {8'h55, 8'h36, 8'h00}, 2, v);
        10: emit({8'hb8, le_bytes(v), 8'h0}, 5, {8'h33, 16'h0}, 1, v);
        11: emit({8'he8, le_bytes(v), 8'h0}, 5, {8'h12, 8'h13, 8'h42}, 3, v);
        default: begin
                while (w[7:0] inside {8'h55, 8'h53, 8'h5d, 8'hc3, 8'hc9, 8'h89, 8'h6a,
                                      8'h83, 8'h8b, 8'hb8, 8'he8})
                        w = next_rand();
                emit({w[7:0], 40'h0}, 1, 24'h0, 1, '0);         // unknown, load none
        end
        endcase
endtask

`endif

// File: test/tb_front_end.sv
`timescale 1ns/1ps

module tb_front_end;

        localparam int          QUEUE_DEPTH = 4;
        localparam logic [31:0] RESET_EIP   = 32'h0040_1000;
        localparam int          N_INSN      = 300;

        logic                 reset;            // clock port of the dut
        logic                 clk2;             // async reset, active high
        logic [7:0]           code_byte;
        logic                 code_valid;
        logic                 code_ready;
        x86_decode_pkg::uop_t uop;
        logic                 uop_valid;
        logic                 uop_ready;
        logic [31:0]          eip;

        logic [31:0]          rng;
        logic [7:0]           byte_q[$];        // code stream not yet sent
        logic                 end_q[$];         // last byte of an instruction
        x86_decode_pkg::uop_t pend_q[$];        // steps of instructions not fully fed
        logic [31:0]          pend_next_q[$];
        int                   pend_cnt_q[$];
        x86_decode_pkg::uop_t exp_q[$];         // steps allowed to come out
        logic [31:0]          exp_next_q[$];
        logic [31:0]          gen_eip;
        logic [31:0]          exp_eip;
        logic                 eip_due;
        logic                 started;
        int                   stall_left;
        int                   total_bytes;

        x86_front_end #(
                .QUEUE_DEPTH (QUEUE_DEPTH),
                .RESET_EIP   (RESET_EIP)
        ) i_dut (
                .reset      (reset),
                .clk2       (clk2),
                .code_byte  (code_byte),
                .code_valid (code_valid),
                .code_ready (code_ready),
                .uop        (uop),
                .uop_valid  (uop_valid),
                .uop_ready  (uop_ready),
                .eip        (eip)
        );

        bind x86_front_end front_end_assertions i_checks (
                .reset      (reset),
                .clk2       (clk2),
                .code_ready (code_ready),
                .uop        (uop),
                .uop_valid  (uop_valid),
                .uop_ready  (uop_ready),
                .eip        (eip)
        );

        always #4 reset = ~reset;               // 8 ns period

        function automatic logic [31:0] next_rand();
                rng = rng * 32'd1664525 + 32'd1013904223;
                return rng;
        endfunction

        function automatic int unsigned rand_below(input int unsigned n);
                logic [31:0] r;
                r = next_rand();
                return (r >> 8) % n;            // low bits of an lcg are weak
        endfunction

        `include "tb_ref_model.svh"

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("=== FAIL ===");
                $fatal(1, "run stopped");
        endtask

        task automatic check_uop(input x86_decode_pkg::uop_t got,
                                 input x86_decode_pkg::uop_t want);
                string msg;
                if (got !== want) begin
                        msg = $sformatf("ERR %0t uop got load=%0d sel=%0d imm=%h eip=%h last=%b",
                                        $time, got.load, got.select, got.imm, got.eip, got.last);
                        msg = {msg, $sformatf(" expected load=%0d sel=%0d imm=%h eip=%h last=%b",
                                              want.load, want.select, want.imm, want.eip,
                                              want.last)};
                        stop_run(msg);
                end
        endtask

        task automatic check_eip(input logic [31:0] got, input logic [31:0] want);
                if (got !== want)
                        stop_run($sformatf("ERR %0t eip got %h expected %h", $time, got, want));
        endtask

        // all steps of a fully fed instruction may now appear
        task automatic release_steps();
                int k;
                k = pend_cnt_q.pop_front();
                repeat (k) begin
                        exp_q.push_back(pend_q.pop_front());
                        exp_next_q.push_back(pend_next_q.pop_front());
                end
        endtask

        // called on each falling edge, outputs stay put until the next rising edge
        task automatic drive_cycle();
                x86_decode_pkg::uop_t want;
                logic [31:0]          r;
                if (eip_due) begin
                        check_eip(eip, exp_eip);
                        eip_due = 1'b0;
                end
                r = next_rand();
                code_byte = r[15:8];            // junk while idle
                code_valid = 1'b0;
                if (byte_q.size() != 0 && rand_below(4) != 0) begin
                        code_valid = 1'b1;
                        code_byte = byte_q[0];
                        if (code_ready) begin   // taken on the coming rising edge
                                if (end_q[0])
                                        release_steps();
                                void'(byte_q.pop_front());
                                void'(end_q.pop_front());
                        end
                end
                if (stall_left != 0) begin
                        uop_ready = 1'b0;
                        stall_left = stall_left - 1;
                end else if (rand_below(24) == 0) begin
                        uop_ready = 1'b0;       // long stall fills the queue
                        stall_left = 8 + int'(rand_below(32));
                end else begin
                        uop_ready = (rand_below(4) != 0);
                end
                if (uop_valid && exp_q.size() == 0) begin
                        stop_run("uop_valid went high with no complete instruction fed in");
                end else if (uop_valid && uop_ready) begin
                        want = exp_q.pop_front();
                        exp_eip = exp_next_q.pop_front();
                        check_uop(uop, want);
                        if (want.last)
                                eip_due = 1'b1;
                end
        endtask

        initial begin
                reset = 1'b0;
                clk2 = 1'b1;
                code_byte = '0;
                code_valid = 1'b0;
                uop_ready = 1'b0;
                rng = 32'd59336;
                gen_eip = RESET_EIP;
                exp_eip = RESET_EIP;
                eip_due = 1'b1;                 // first check is the reset value
                stall_left = 0;
                started = 1'b0;
                repeat (N_INSN)
                        gen_insn();
                total_bytes = byte_q.size();
                started = 1'b1;
                repeat (5) @(posedge reset);
                @(negedge reset);
                clk2 = 1'b0;
                while (byte_q.size() != 0 || pend_cnt_q.size() != 0 || exp_q.size() != 0) begin
                        drive_cycle();
                        @(negedge reset);
                end
                repeat (20) begin               // no stray steps after the stream
                        drive_cycle();
                        @(negedge reset);
                end
                $display("%0d instructions, %0d code bytes checked", N_INSN, total_bytes);
                $display("=== PASS ===");
                $finish;
        end

        initial begin
                wait (started);
                repeat (total_bytes * 40 + 400) @(posedge reset);
                stop_run("watchdog expired, the uop output stalled before all steps came out");
        end

endmodule

// File: verilog/insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
        input  logic                  reset,
        input  logic                  clk2,
        input  x86_decode_pkg::insn_t insn,
        input  logic                  insn_valid,
        output logic                  insn_ready,
        output x86_decode_pkg::dec_t  dec,
        output logic                  dec_valid,
        input  logic                  dec_ready
);

        x86_decode_pkg::insn_bytes_u w;
        x86_decode_pkg::dec_t        nxt;
        logic [7:0]                  op;
        logic [7:0]                  modrm;
        logic [31:0]                 sext8;     // imm8 or disp8 in byte 2
        logic                        take;

        function automatic logic [31:0] le32(input logic [31:0] b);
                return {b[7:0], b[15:8], b[23:16], b[31:24]};
        endfunction

        function automatic x86_decode_pkg::step_t mk(input x86_decode_pkg::reg_code_t load,
                                                     input x86_decode_pkg::sel_code_t sel);
                return '{load: load, select: sel, valid: 1'b1};
        endfunction

        assign w = insn.window;
        assign op = w.modrm_view.opcode;
        assign modrm = w.modrm_view.modrm;
        assign sext8 = {{24{w.modrm_view.disp[31]}}, w.modrm_view.disp[31:24]};

        always_comb begin
                nxt = '0;
                nxt.length = insn.length;
                nxt.step[0] = mk(x86_decode_pkg::REG_NONE, 4'h0);     // unknown form
                case (op)
                8'h55, 8'h53: begin                     // push ebp / ebx
                        nxt.step[0] = mk(x86_decode_pkg::REG_ESP, 4'h2);
                        nxt.step[1] = mk(x86_decode_pkg::REG_ESP, (op == 8'h55) ? 4'h1 : 4'h7);
                end
                8'h89: begin
                        if (modrm >= 8'he5)
                                nxt.step[0] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h2);
                        else if (modrm >= 8'hc3)
                                nxt.step[0] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h6);
                end
                8'hb8: begin
                        nxt.step[0] = mk(x86_decode_pkg::REG_EAX, 4'h3);
                        nxt.imm = le32(w.imm_view.imm);
                end
                8'h5d: begin                            // pop ebp
                        nxt.step[0] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h4);
                        nxt.step[1] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h2);
                end
                8'hc3: begin                            // ret
                        nxt.step[0] = mk(x86_decode_pkg::REG_EIP, 4'h4);
                        nxt.step[1] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h2);
                end
                8'he8: begin                            // call rel32
                        nxt.step[0] = mk(x86_decode_pkg::REG_ESP, 4'h2);
                        nxt.step[1] = mk(x86_decode_pkg::REG_ESP, 4'h3);
                        nxt.step[2] = mk(x86_decode_pkg::REG_EIP, 4'h2);
                        nxt.imm = le32(w.imm_view.imm);
                end
                8'h6a: begin
                        nxt.step[0] = mk(x86_decode_pkg::REG_ESP, 4'h2);
                        nxt.step[1] = mk(x86_decode_pkg::REG_ESP, 4'h4);
                        nxt.imm = {{24{modrm[7]}}, modrm};      // imm8 sits in modrm slot
                end
                8'h8b: begin
                        if (modrm inside {[8'h40:8'h47], [8'h80:8'h87]}) begin
                                nxt.step[0] = mk(x86_decode_pkg::REG_STACK, 4'h5);
                                nxt.step[1] = mk(x86_decode_pkg::REG_EAX, 4'h6);
                                nxt.imm = modrm[7] ? le32(w.modrm_view.disp) : sext8;
                        end
                end
                8'h83: begin
                        if (modrm == 8'he8)
                                nxt.step[0] = mk(x86_decode_pkg::REG_EAX, 4'h6);
                        else if (modrm inside {8'hc4, 8'hec})
                                nxt.step[0] = mk(x86_decode_pkg::REG_ESP, 4'h2);
                        if (modrm inside {8'he8, 8'hc4, 8'hec})
                                nxt.imm = sext8;
                end
                8'hc9: begin                            // leave
                        nxt.step[0] = mk(x86_decode_pkg::REG_ESP, 4'h5);
                        nxt.step[1] = mk(x86_decode_pkg::REG_STACK, 4'h5);
                        nxt.step[2] = mk(x86_decode_pkg::REG_EBP_EBX, 4'h1);
                end
                default: nxt.imm = '0;
                endcase
                nxt.count = {1'b0, nxt.step[0].valid} + {1'b0, nxt.step[1].valid} +
                            {1'b0, nxt.step[2].valid};
        end

        assign insn_ready = !dec_valid || dec_ready;
        assign take = insn_valid && insn_ready;

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2)
                        dec_valid <= 1'b0;
                else if (insn_ready)
                        dec_valid <= insn_valid;
        end

        always_ff @(posedge reset) begin
                if (take)
                        dec <= nxt;
        end

endmodule

// File: verilog/insn_fetch.sv
`timescale 1ns/1ps

module insn_fetch (
        input  logic                  reset,
        input  logic                  clk2,
        input  logic [7:0]            code_byte,
        input  logic                  code_valid,
        output logic                  code_ready,
        output x86_decode_pkg::insn_t insn,
        output logic                  insn_valid,
        input  logic                  insn_ready
);

        logic [0:5][7:0] win;           // byte 0 is the opcode
        logic [2:0]      count;         // bytes collected so far
        logic [0:5][7:0] nxt_win;
        logic [2:0]      nxt_count;
        logic [3:0]      len;
        logic            len_known;
        logic            take;
        logic            done;
        logic            run;           // low until the first cycle after reset

        assign code_ready = run && !insn_valid;         // stall while a frame waits
        assign take = code_valid && code_ready;

        always_comb begin
                nxt_win = win;
                nxt_count = count;
                if (take) begin
                        nxt_win[count] = code_byte;
                        nxt_count = count + 3'd1;
                end
        end

        assign len = x86_decode_pkg::insn_length(nxt_win[0], nxt_win[1]);
        assign len_known = (nxt_count >= 3'd2) ||
                (nxt_count == 3'd1 && !x86_decode_pkg::needs_modrm(nxt_win[0]));
        assign done = len_known && !insn_valid && ({1'b0, nxt_count} >= len);

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        count <= '0;
                        insn_valid <= 1'b0;
                        run <= 1'b0;
                end else begin
                        run <= 1'b1;
                        if (insn_valid && insn_ready)
                                insn_valid <= 1'b0;
                        if (done) begin
                                insn_valid <= 1'b1;
                                // a rejected modrm byte opens the next frame
                                count <= ({1'b0, nxt_count} > len) ? 3'd1 : 3'd0;
                        end else begin
                                count <= nxt_count;
                        end
                end
        end

        always_ff @(posedge reset) begin
                if (done) begin
                        insn.window <= nxt_win;
                        insn.length <= len;
                        win[0] <= nxt_win[1];   // carried byte, if any
                end else begin
                        win <= nxt_win;
                end
        end

endmodule

// File: verilog/insn_queue.sv
`timescale 1ns/1ps

module insn_queue #(
        parameter int QUEUE_DEPTH = 4
) (
        input  logic                  reset,
        input  logic                  clk2,
        input  x86_decode_pkg::insn_t in_insn,
        input  logic                  in_valid,
        output logic                  in_ready,
        output x86_decode_pkg::insn_t out_insn,
        output logic                  out_valid,
        input  logic                  out_ready
);

        localparam int PTR_W = $clog2(QUEUE_DEPTH);

        x86_decode_pkg::insn_t mem [QUEUE_DEPTH];
        logic [PTR_W-1:0]      wr_ptr;
        logic [PTR_W-1:0]      rd_ptr;
        logic [PTR_W:0]        used;    // occupancy
        logic                  wr;
        logic                  rd;

        assign out_valid = (used != '0);
        assign in_ready = (used != (PTR_W+1)'(QUEUE_DEPTH)) || out_ready;
        assign out_insn = mem[rd_ptr];
        assign wr = in_valid && in_ready;
        assign rd = out_valid && out_ready;

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        used <= '0;
                end else begin
                        if (wr)
                                wr_ptr <= wr_ptr + 1'b1;        // wraps, depth is 2**n
                        if (rd)
                                rd_ptr <= rd_ptr + 1'b1;
                        case ({wr, rd})
                        2'b10: used <= used + 1'b1;
                        2'b01: used <= used - 1'b1;
                        default: used <= used;
                        endcase
                end
        end

        always_ff @(posedge reset) begin
                if (wr)
                        mem[wr_ptr] <= in_insn;
        end

endmodule

// File: verilog/uop_issue.sv
`timescale 1ns/1ps

module uop_issue #(
        parameter logic [31:0] RESET_EIP = 32'h0
) (
        input  logic                 reset,
        input  logic                 clk2,
        input  x86_decode_pkg::dec_t dec,
        input  logic                 dec_valid,
        output logic                 dec_ready,
        output x86_decode_pkg::uop_t uop,
        output logic                 uop_valid,
        input  logic                 uop_ready,
        output logic [31:0]          eip
);

        x86_decode_pkg::step_t cur;
        logic [1:0]            idx;     // step being offered
        logic                  last;
        logic                  fire;

        assign cur = dec.step[idx];
        assign last = (idx == dec.count - 2'd1);
        assign uop_valid = dec_valid && cur.valid;
        assign fire = uop_valid && uop_ready;
        assign dec_ready = fire && last;        // release only after final step

        assign uop.load = cur.load;
        assign uop.select = cur.select;
        assign uop.imm = dec.imm;
        assign uop.eip = eip;
        assign uop.last = last;

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        idx <= 2'd0;
                        eip <= RESET_EIP;
                end else if (fire) begin
                        if (last) begin
                                idx <= 2'd0;
                                eip <= eip + 32'(dec.length);   // sequential only
                        end else begin
                                idx <= idx + 2'd1;
                        end
                end
        end

endmodule

// File: verilog/x86_decode_pkg.sv
package x86_decode_pkg;

        typedef enum logic [3:0] {
                REG_NONE    = 4'd0,
                REG_ESP     = 4'd1,
                REG_EBP_EBX = 4'd2,     // which one follows from modrm
                REG_EAX     = 4'd3,
                REG_EIP     = 4'd4,
                REG_STACK   = 4'd5      // stack access register
        } reg_code_t;

        typedef logic [3:0] sel_code_t;         // alu source select, 1 to 7

        typedef struct packed {
                logic [7:0]  opcode;
                logic [7:0]  modrm;
                logic [31:0] disp;      // stream order, disp8 in top byte
        } modrm_view_t;

        typedef struct packed {
                logic [7:0]  opcode;
                logic [31:0] imm;       // stream order, little endian value
                logic [7:0]  pad;
        } imm_view_t;

        // six byte window, opcode always in the top byte
        typedef union packed {
                modrm_view_t modrm_view;
                imm_view_t   imm_view;
        } insn_bytes_u;

        typedef struct packed {
                insn_bytes_u window;
                logic [3:0]  length;    // 1 to 6 bytes
        } insn_t;

        typedef struct packed {
                reg_code_t   load;
                sel_code_t   select;
                logic [31:0] imm;
                logic [31:0] eip;       // address of the first byte
                logic        last;
        } uop_t;

        typedef struct packed {
                reg_code_t load;
                sel_code_t select;
                logic      valid;
        } step_t;

        typedef struct packed {
                step_t [0:2] step;
                logic [31:0] imm;
                logic [3:0]  length;
                logic [1:0]  count;     // valid steps, 1 to 3
        } dec_t;

        // opcodes whose length depends on the modrm byte
        function automatic logic needs_modrm(input logic [7:0] opcode);
                return opcode inside {8'h89, 8'h83, 8'h8b};
        endfunction

        function automatic logic [3:0] insn_length(input logic [7:0] opcode,
                                                   input logic [7:0] modrm);
                logic [3:0] len;
                len = 4'd1;                     // unknown forms take one byte
                case (opcode)
                8'h89: if (modrm >= 8'hc3) len = 4'd2;
                8'h6a: len = 4'd2;
                8'h83: if (modrm inside {8'he8, 8'hc4, 8'hec}) len = 4'd3;
                8'h8b: begin
                        if (modrm inside {[8'h40:8'h47]}) len = 4'd3;
                        if (modrm inside {[8'h80:8'h87]}) len = 4'd6;
                end
                8'hb8, 8'he8: len = 4'd5;
                default: len = 4'd1;
                endcase
                return len;
        endfunction

endpackage

// File: verilog/x86_front_end.sv
`timescale 1ns/1ps

module x86_front_end #(
        parameter int          QUEUE_DEPTH = 4,
        parameter logic [31:0] RESET_EIP   = 32'h0
) (
        input  logic                 reset,
        input  logic                 clk2,
        input  logic [7:0]           code_byte,
        input  logic                 code_valid,
        output logic                 code_ready,
        output x86_decode_pkg::uop_t uop,
        output logic                 uop_valid,
        input  logic                 uop_ready,
        output logic [31:0]          eip
);

        x86_decode_pkg::insn_t f_insn;  // fetch to queue
        logic                  f_valid;
        logic                  f_ready;
        x86_decode_pkg::insn_t q_insn;  // queue to decode
        logic                  q_valid;
        logic                  q_ready;
        x86_decode_pkg::dec_t  dec;
        logic                  dec_valid;
        logic                  dec_ready;

        insn_fetch i_fetch (
                .reset      (reset),
                .clk2       (clk2),
                .code_byte  (code_byte),
                .code_valid (code_valid),
                .code_ready (code_ready),
                .insn       (f_insn),
                .insn_valid (f_valid),
                .insn_ready (f_ready)
        );

        insn_queue #(
                .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_queue (
                .reset     (reset),
                .clk2      (clk2),
                .in_insn   (f_insn),
                .in_valid  (f_valid),
                .in_ready  (f_ready),
                .out_insn  (q_insn),
                .out_valid (q_valid),
                .out_ready (q_ready)
        );

        insn_decode i_decode (
                .reset      (reset),
                .clk2       (clk2),
                .insn       (q_insn),
                .insn_valid (q_valid),
                .insn_ready (q_ready),
                .dec        (dec),
                .dec_valid  (dec_valid),
                .dec_ready  (dec_ready)
        );

        uop_issue #(
                .RESET_EIP (RESET_EIP)
        ) i_issue (
                .reset     (reset),
                .clk2      (clk2),
                .dec       (dec),
                .dec_valid (dec_valid),
                .dec_ready (dec_ready),
                .uop       (uop),
                .uop_valid (uop_valid),
                .uop_ready (uop_ready),
                .eip       (eip)
        );

endmodule
